/* list.f */
hdl/prf_pkg.sv
hdl/prf_bank_write_if.sv
hdl/prf_rotate_pick.sv
hdl/prf_read_arbiter.sv
hdl/prf_wb_arbiter.sv
hdl/prf_bank_array.sv
hdl/prf_top.sv
bench/prf_clock_gen.sv
bench/prf_properties.sv
bench/prf_tb.sv

/* Makefile */
# Verilator build and run for the register file testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := prf_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/prf_tb.sv */
// ----------------------------------------
// register file testbench
// ----------------------------------------
`timescale 1ns/1ps

module prf_tb;
    import prf_pkg::*;

    localparam int RR_COUNT        = 9;
    localparam int WR_COUNT        = 7;
    localparam int RESET_READS     = 8;
    localparam int RANDOM_OPS      = 60;
    localparam int CONFLICT_ROUNDS = 6;
    localparam int OP_COUNT        = RESET_READS + RANDOM_OPS + 2 + 2 * CONFLICT_ROUNDS;
    localparam int WATCHDOG_CYCLES = OP_COUNT * (RR_COUNT + WR_COUNT) + 50;

    logic                              CLK;
    logic                              nRST;
    logic       [RR_COUNT-1:0]         read_req_valid;
    pr_t        [RR_COUNT-1:0]         read_req_pr;
    logic       [RR_COUNT-1:0]         read_resp_ack;
    logic       [RR_COUNT-1:0]         read_resp_port;
    reg_data_t  [BANK_COUNT-1:0][1:0]  read_data;
    logic       [WR_COUNT-1:0]         WB_valid;
    reg_data_t  [WR_COUNT-1:0]         WB_data;
    pr_t        [WR_COUNT-1:0]         WB_pr;
    rob_index_t [WR_COUNT-1:0]         WB_rob_index;
    logic       [WR_COUNT-1:0]         WB_ready;
    logic       [BANK_COUNT-1:0]       WB_bus_valid;
    upper_pr_t  [BANK_COUNT-1:0]       WB_bus_upper_pr;
    logic       [BANK_COUNT-1:0]       complete_bus_valid;
    rob_index_t [BANK_COUNT-1:0]       complete_bus_rob_index;

    // last value written to each register
    reg_data_t                 shadow [PR_COUNT];
    pr_t       [RR_COUNT-1:0]  pending_pr;
    reg_data_t [RR_COUNT-1:0]  expected_data;
    reg_data_t [RR_COUNT-1:0]  resp_data;
    logic      [31:0]          rng = 32'hbe11_a96a;
    string                     test_name = "reset";

    prf_clock_gen i_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    prf_top #(.RR_COUNT(RR_COUNT), .WR_COUNT(WR_COUNT)) i_prf_top (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual)
        else report_failure($sformatf("** Error: %s %s expected %h actual %h",
            test_name, what, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    // ----------------------------------------
    // read data against the shadow copy

    always_comb begin
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            expected_data[rr] = shadow[pending_pr[rr]];
            resp_data[rr] = read_data[pending_pr[rr][LOG_BANK_COUNT-1:0]][read_resp_port[rr]];
        end
    end

    for (genvar rr = 0; rr < RR_COUNT; rr++) begin : g_read_check
        assert property (@(posedge CLK) disable iff (!nRST)
            read_resp_ack[rr] |-> resp_data[rr] == expected_data[rr])
        else report_failure($sformatf("** Error: %s read of PR %0d expected %h actual %h",
            test_name, $sampled(pending_pr[rr]), $sampled(expected_data[rr]),
            $sampled(resp_data[rr])));
    end

    task automatic present_write(input int wr, input pr_t pr, output rob_index_t rob);
        rng = xorshift(rng);
        rob = rob_index_t'(rng >> 25);
        WB_valid[wr]     = 1'b1;
        WB_pr[wr]        = pr;
        WB_data[wr]      = rng;
        WB_rob_index[wr] = rob;
        if (pr != '0) begin
            shadow[pr] = rng;
        end
    endtask

    // one write, bus checked the cycle after acceptance
    task automatic write_reg(input int wr, input pr_t pr);
        rob_index_t rob;
        bank_t      bank;
        bank = pr[LOG_BANK_COUNT-1:0];
        while (!WB_ready[wr]) next_cycle();
        present_write(wr, pr, rob);
        next_cycle();
        WB_valid[wr] = 1'b0;
        check_value("WB_bus_valid", 32'(pr != '0), 32'(WB_bus_valid[bank]));
        check_value("WB_bus_upper_pr", 32'(pr >> LOG_BANK_COUNT), 32'(WB_bus_upper_pr[bank]));
        check_value("complete_bus_valid", 32'd1, 32'(complete_bus_valid[bank]));
        check_value("complete_bus_rob_index", 32'(rob), 32'(complete_bus_rob_index[bank]));
    endtask

    // idle bank acks in the very next cycle
    task automatic read_reg(input int rr, input pr_t pr);
        read_req_valid[rr] = 1'b1;
        read_req_pr[rr]    = pr;
        pending_pr[rr]     = pr;
        next_cycle();
        read_req_valid[rr] = 1'b0;
        check_value("read_resp_ack", 32'd1, 32'(read_resp_ack[rr]));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        pr_t                 pr;
        bank_t               bank;
        rob_index_t          rob;
        logic [RR_COUNT-1:0] acked;
        read_req_valid = '0;
        read_req_pr    = '0;
        WB_valid       = '0;
        WB_data        = '0;
        WB_pr          = '0;
        WB_rob_index   = '0;
        pending_pr     = '0;
        for (int i = 0; i < PR_COUNT; i++) begin
            shadow[i] = '0;
        end
        @(posedge nRST);
        next_cycle();

        check_value("read_resp_ack", 32'd0, 32'(read_resp_ack));
        check_value("read_resp_port", 32'd0, 32'(read_resp_port));
        check_value("WB_bus_valid", 32'd0, 32'(WB_bus_valid));
        check_value("complete_bus_valid", 32'd0, 32'(complete_bus_valid));
        check_value("WB_ready", 32'({WR_COUNT{1'b1}}), 32'(WB_ready));
        for (int i = 0; i < RESET_READS; i++) begin
            rng = xorshift(rng);
            read_reg(i % RR_COUNT, pr_t'(rng));
        end

        test_name = "random write and read";
        for (int op = 0; op < RANDOM_OPS; op++) begin
            rng = xorshift(rng);
            pr = pr_t'(rng);
            write_reg(int'(rng[15:8]) % WR_COUNT, pr);
            next_cycle();
            read_reg(int'(rng[23:16]) % RR_COUNT, pr);
        end

        test_name = "write to PR 0";
        write_reg(0, '0);
        next_cycle();
        read_reg(1, '0);

        // every writer and requester hits one bank
        test_name = "bank conflicts";
        for (int round = 0; round < CONFLICT_ROUNDS; round++) begin
            rng = xorshift(rng);
            bank = bank_t'(rng);
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                present_write(wr, {upper_pr_t'(wr * 4 + round), bank}, rob);
            end
            next_cycle();
            WB_valid = '0;
            while (WB_ready != '1) next_cycle();
            next_cycle();
            next_cycle();
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                rng = xorshift(rng);
                pr = {upper_pr_t'(rng), bank};
                read_req_valid[rr] = 1'b1;
                read_req_pr[rr]    = pr;
                pending_pr[rr]     = pr;
            end
            next_cycle();
            read_req_valid = '0;
            acked = read_resp_ack;
            while (acked != '1) begin
                next_cycle();
                acked |= read_resp_ack;
            end
        end

        next_cycle();
        if (i_prf_top.i_prf_properties.error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_failure("protocol assertions failed in the bound checker");
        end
    end

endmodule

/* bench/prf_properties.sv */
// ----------------------------------------
// register file protocol checks
// ----------------------------------------
`timescale 1ns/1ps

module prf_properties #(
    parameter int RR_COUNT = 9,
    parameter int WR_COUNT = 7
) (
    input logic                           CLK,
    input logic                           nRST,
    input logic         [RR_COUNT-1:0]    read_req_valid,
    input prf_pkg::pr_t [RR_COUNT-1:0]    read_req_pr,
    input logic         [RR_COUNT-1:0]    read_resp_ack,
    input logic         [WR_COUNT-1:0]    WB_valid,
    input prf_pkg::pr_t [WR_COUNT-1:0]    WB_pr,
    input logic         [WR_COUNT-1:0]    WB_ready,
    input logic [prf_pkg::BANK_COUNT-1:0] complete_bus_valid
);
    import prf_pkg::*;

    int error_count = 0;

    // outstanding reads and writes with bank and age
    logic  [RR_COUNT-1:0] read_pending;
    bank_t [RR_COUNT-1:0] read_bank;
    int                   read_age [RR_COUNT];
    logic  [WR_COUNT-1:0] write_pending;
    bank_t [WR_COUNT-1:0] write_bank;
    int                   write_age [WR_COUNT];

    logic [WR_COUNT-1:0] completing;
    int                  ack_count [BANK_COUNT];
    int                  complete_count [BANK_COUNT];

    // a held write finishes in the cycle its ready comes back
    assign completing = write_pending & WB_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_pending  <= '0;
            read_bank     <= '0;
            write_pending <= '0;
            write_bank    <= '0;
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                read_age[rr] <= 0;
            end
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                write_age[wr] <= 0;
            end
        end else begin
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                if (read_req_valid[rr]) begin
                    read_pending[rr] <= 1'b1;
                    read_bank[rr]    <= read_req_pr[rr][LOG_BANK_COUNT-1:0];
                    read_age[rr]     <= 1;
                end else if (read_resp_ack[rr]) begin
                    read_pending[rr] <= 1'b0;
                end else if (read_pending[rr]) begin
                    read_age[rr] <= read_age[rr] + 1;
                end
            end
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                if (WB_valid[wr] && WB_ready[wr]) begin
                    write_pending[wr] <= 1'b1;
                    write_bank[wr]    <= WB_pr[wr][LOG_BANK_COUNT-1:0];
                    write_age[wr]     <= 1;
                end else if (completing[wr]) begin
                    write_pending[wr] <= 1'b0;
                end else if (write_pending[wr]) begin
                    write_age[wr] <= write_age[wr] + 1;
                end
            end
        end
    end

    // ----------------------------------------
    // per-bank counts

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            ack_count[b]      = 0;
            complete_count[b] = 0;
        end
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            if (read_resp_ack[rr]) begin
                ack_count[read_bank[rr]] += 1;
            end
        end
        for (int wr = 0; wr < WR_COUNT; wr++) begin
            if (completing[wr]) begin
                complete_count[write_bank[wr]] += 1;
            end
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        assert property (@(posedge CLK) disable iff (!nRST) ack_count[b] <= 2)
        else begin
            $error("more than two read acks in bank %0d", b);
            error_count++;
        end
        assert property (@(posedge CLK) disable iff (!nRST)
            complete_bus_valid[b] == (complete_count[b] == 1) && complete_count[b] <= 1)
        else begin
            $error("completion count mismatch in bank %0d", b);
            error_count++;
        end
    end

    for (genvar rr = 0; rr < RR_COUNT; rr++) begin : g_read
        assert property (@(posedge CLK) disable iff (!nRST)
            read_resp_ack[rr] |-> read_pending[rr] && read_age[rr] <= RR_COUNT)
        else begin
            $error("read ack for requester %0d is late or unexpected", rr);
            error_count++;
        end
        assert property (@(posedge CLK) disable iff (!nRST)
            read_pending[rr] && !read_resp_ack[rr] |-> !read_req_valid[rr]
                && read_age[rr] < RR_COUNT)
        else begin
            $error("requester %0d re-issued or waited too long", rr);
            error_count++;
        end
    end

    for (genvar wr = 0; wr < WR_COUNT; wr++) begin : g_write
        assert property (@(posedge CLK) disable iff (!nRST)
            write_pending[wr] |-> write_age[wr] <= WR_COUNT)
        else begin
            $error("write from writer %0d did not complete in time", wr);
            error_count++;
        end
        assert property (@(posedge CLK) disable iff (!nRST)
            !write_pending[wr] |-> WB_ready[wr])
        else begin
            $error("WB_ready low for idle writer %0d", wr);
            error_count++;
        end
    end

endmodule

bind prf_top prf_properties #(
    .RR_COUNT (RR_COUNT),
    .WR_COUNT (WR_COUNT)
) i_prf_properties (
    .CLK                (CLK),
    .nRST               (nRST),
    .read_req_valid     (read_req_valid),
    .read_req_pr        (read_req_pr),
    .read_resp_ack      (read_resp_ack),
    .WB_valid           (WB_valid),
    .WB_pr              (WB_pr),
    .WB_ready           (WB_ready),
    .complete_bus_valid (complete_bus_valid)
);

/* bench/prf_clock_gen.sv */
// ----------------------------------------
// testbench clock and reset
// ----------------------------------------
`timescale 1ns/1ps

module prf_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // release just after an edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

/* hdl/prf_top.sv */
// ----------------------------------------
// banked physical register file
// ----------------------------------------
`timescale 1ns/1ps

module prf_top #(
    parameter int RR_COUNT = 9,
    parameter int WR_COUNT = 7
) (
    input  logic                                              CLK,
    input  logic                                              nRST,

    // read requests and responses
    input  logic                [RR_COUNT-1:0]                read_req_valid,
    input  prf_pkg::pr_t        [RR_COUNT-1:0]                read_req_pr,
    output logic                [RR_COUNT-1:0]                read_resp_ack,
    output logic                [RR_COUNT-1:0]                read_resp_port,
    output prf_pkg::reg_data_t  [prf_pkg::BANK_COUNT-1:0][1:0] read_data,

    // writeback requests
    input  logic                [WR_COUNT-1:0]                WB_valid,
    input  prf_pkg::reg_data_t  [WR_COUNT-1:0]                WB_data,
    input  prf_pkg::pr_t        [WR_COUNT-1:0]                WB_pr,
    input  prf_pkg::rob_index_t [WR_COUNT-1:0]                WB_rob_index,
    output logic                [WR_COUNT-1:0]                WB_ready,

    // writeback and completion buses
    output logic                [prf_pkg::BANK_COUNT-1:0]     WB_bus_valid,
    output prf_pkg::upper_pr_t  [prf_pkg::BANK_COUNT-1:0]     WB_bus_upper_pr,
    output logic                [prf_pkg::BANK_COUNT-1:0]     complete_bus_valid,
    output prf_pkg::rob_index_t [prf_pkg::BANK_COUNT-1:0]     complete_bus_rob_index
);
    import prf_pkg::*;

    upper_pr_t [BANK_COUNT-1:0] next_port0_upper_pr;
    upper_pr_t [BANK_COUNT-1:0] next_port1_upper_pr;

    prf_bank_write_if wb_if ();

    prf_read_arbiter #(.RR_COUNT(RR_COUNT)) i_read_arbiter (
        .CLK                 (CLK),
        .nRST                (nRST),
        .read_req_valid      (read_req_valid),
        .read_req_pr         (read_req_pr),
        .read_resp_ack       (read_resp_ack),
        .read_resp_port      (read_resp_port),
        .next_port0_upper_pr (next_port0_upper_pr),
        .next_port1_upper_pr (next_port1_upper_pr)
    );

    prf_wb_arbiter #(.WR_COUNT(WR_COUNT)) i_wb_arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .WB_valid     (WB_valid),
        .WB_data      (WB_data),
        .WB_pr        (WB_pr),
        .WB_rob_index (WB_rob_index),
        .WB_ready     (WB_ready),
        .wb           (wb_if.source)
    );

    prf_bank_array i_bank_array (
        .CLK                 (CLK),
        .nRST                (nRST),
        .next_port0_upper_pr (next_port0_upper_pr),
        .next_port1_upper_pr (next_port1_upper_pr),
        .wb                  (wb_if.sink),
        .read_data           (read_data)
    );

    // writeback stage drives both buses
    assign WB_bus_valid           = wb_if.wb_valid;
    assign WB_bus_upper_pr        = wb_if.wb_upper_pr;
    assign complete_bus_valid     = wb_if.complete_valid;
    assign complete_bus_rob_index = wb_if.complete_rob_index;

endmodule

/* hdl/prf_bank_array.sv */
// ----------------------------------------
// banked register storage
// ----------------------------------------
`timescale 1ns/1ps

module prf_bank_array (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]     next_port0_upper_pr,
    input  prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]     next_port1_upper_pr,
    prf_bank_write_if.sink                                   wb,
    output prf_pkg::reg_data_t [prf_pkg::BANK_COUNT-1:0][1:0] read_data
);
    import prf_pkg::*;

    localparam int ROW_COUNT = PR_COUNT / BANK_COUNT;

    reg_data_t mem [BANK_COUNT][ROW_COUNT];

    // read rows granted last cycle
    upper_pr_t [BANK_COUNT-1:0] port0_row;
    upper_pr_t [BANK_COUNT-1:0] port1_row;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            port0_row <= '0;
            port1_row <= '0;
        end else begin
            port0_row <= next_port0_upper_pr;
            port1_row <= next_port1_upper_pr;
        end
    end

    // ----------------------------------------
    // storage, zeroed so register 0 reads zero

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                for (int r = 0; r < ROW_COUNT; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb.wb_valid[b]) begin
                    mem[b][wb.wb_upper_pr[b]] <= wb.wb_data[b];
                end
            end
        end
    end

    // asynchronous reads
    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            read_data[b][0] = mem[b][port0_row[b]];
            read_data[b][1] = mem[b][port1_row[b]];
        end
    end

endmodule

/* hdl/prf_wb_arbiter.sv */
// ----------------------------------------
// banked writeback arbiter
// ----------------------------------------
`timescale 1ns/1ps

module prf_wb_arbiter #(
    parameter int WR_COUNT = 7
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                [WR_COUNT-1:0]    WB_valid,
    input  prf_pkg::reg_data_t  [WR_COUNT-1:0]    WB_data,
    input  prf_pkg::pr_t        [WR_COUNT-1:0]    WB_pr,
    input  prf_pkg::rob_index_t [WR_COUNT-1:0]    WB_rob_index,
    output logic                [WR_COUNT-1:0]    WB_ready,
    prf_bank_write_if.source                      wb
);
    import prf_pkg::*;

    // losing writes wait here with their payload
    logic       [WR_COUNT-1:0] held_valid;
    reg_data_t  [WR_COUNT-1:0] held_data;
    pr_t        [WR_COUNT-1:0] held_pr;
    rob_index_t [WR_COUNT-1:0] held_rob_index;

    logic       [WR_COUNT-1:0] merged_valid;
    reg_data_t  [WR_COUNT-1:0] merged_data;
    pr_t        [WR_COUNT-1:0] merged_pr;
    rob_index_t [WR_COUNT-1:0] merged_rob_index;
    bank_t      [WR_COUNT-1:0] merged_bank;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0] req_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] grant_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] next_last_mask;
    logic [WR_COUNT-1:0]                 ack;

    logic       [BANK_COUNT-1:0] next_wb_valid;
    upper_pr_t  [BANK_COUNT-1:0] next_wb_upper_pr;
    reg_data_t  [BANK_COUNT-1:0] next_wb_data;
    rob_index_t [BANK_COUNT-1:0] next_complete_rob_index;

    // a new valid is dropped while the writer still holds one
    assign merged_valid = (WB_valid & ~held_valid) | held_valid;
    assign WB_ready     = ~held_valid;

    always_comb begin
        req_by_bank = '0;
        for (int wr = 0; wr < WR_COUNT; wr++) begin
            merged_data[wr]      = held_valid[wr] ? held_data[wr] : WB_data[wr];
            merged_pr[wr]        = held_valid[wr] ? held_pr[wr] : WB_pr[wr];
            merged_rob_index[wr] = held_valid[wr] ? held_rob_index[wr] : WB_rob_index[wr];
            merged_bank[wr]      = merged_pr[wr][LOG_BANK_COUNT-1:0];
            req_by_bank[merged_bank[wr]][wr] = merged_valid[wr];
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        prf_rotate_pick #(.WIDTH(WR_COUNT)) i_pick (
            .req       (req_by_bank[b]),
            .last_mask (last_mask[b]),
            .grant     (grant_by_bank[b])
        );
    end

    // ----------------------------------------
    // winner muxes per bank

    always_comb begin
        ack = '0;
        next_last_mask = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            ack |= grant_by_bank[b];
            next_wb_valid[b] = |req_by_bank[b];
            next_wb_upper_pr[b] = '0;
            next_wb_data[b] = '0;
            next_complete_rob_index[b] = '0;
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                next_wb_upper_pr[b] |= upper_pr_t'(merged_pr[wr] >> LOG_BANK_COUNT)
                    & {$bits(upper_pr_t){grant_by_bank[b][wr]}};
                next_wb_data[b] |= merged_data[wr]
                    & {$bits(reg_data_t){grant_by_bank[b][wr]}};
                next_complete_rob_index[b] |= merged_rob_index[wr]
                    & {$bits(rob_index_t){grant_by_bank[b][wr]}};
            end
            for (int wr = 1; wr < WR_COUNT; wr++) begin
                next_last_mask[b][wr] = grant_by_bank[b][wr-1] | next_last_mask[b][wr-1];
            end
        end
        // register 0 still completes but is never written
        if (next_wb_upper_pr[0] == '0) begin
            next_wb_valid[0] = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid        <= '0;
            last_mask         <= '0;
            wb.wb_valid       <= '0;
            wb.complete_valid <= '0;
        end else begin
            held_valid        <= merged_valid & ~ack;
            last_mask         <= next_last_mask;
            wb.wb_valid       <= next_wb_valid;
            // every bank with a request grants exactly one
            wb.complete_valid <= next_complete_valid();
        end
    end

    always_ff @(posedge CLK) begin
        held_data             <= merged_data;
        held_pr               <= merged_pr;
        held_rob_index        <= merged_rob_index;
        wb.wb_upper_pr        <= next_wb_upper_pr;
        wb.wb_data            <= next_wb_data;
        wb.complete_rob_index <= next_complete_rob_index;
    end

    function automatic logic [BANK_COUNT-1:0] next_complete_valid();
        logic [BANK_COUNT-1:0] valid;
        for (int b = 0; b < BANK_COUNT; b++) begin
            valid[b] = |grant_by_bank[b];
        end
        return valid;
    endfunction

endmodule

/* hdl/prf_read_arbiter.sv */
// ----------------------------------------
// banked two-port read arbiter
// ----------------------------------------
`timescale 1ns/1ps

module prf_read_arbiter #(
    parameter int RR_COUNT = 9
) (
    input  logic                                               CLK,
    input  logic                                               nRST,
    input  logic               [RR_COUNT-1:0]                  read_req_valid,
    input  prf_pkg::pr_t       [RR_COUNT-1:0]                  read_req_pr,
    output logic               [RR_COUNT-1:0]                  read_resp_ack,
    output logic               [RR_COUNT-1:0]                  read_resp_port,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]       next_port0_upper_pr,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]       next_port1_upper_pr
);
    import prf_pkg::*;

    // requests still waiting for a port
    logic [RR_COUNT-1:0] held_valid;
    logic [RR_COUNT-1:0] next_held_valid;
    pr_t  [RR_COUNT-1:0] held_pr;

    logic  [RR_COUNT-1:0] merged_valid;
    pr_t   [RR_COUNT-1:0] merged_pr;
    bank_t [RR_COUNT-1:0] merged_bank;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0] req_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port0_grant;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] port1_grant;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] next_last_mask;

    logic [RR_COUNT-1:0] next_ack;
    logic [RR_COUNT-1:0] next_port;

    // ----------------------------------------
    // request routing

    // a held request takes the place of a new one
    assign merged_valid = read_req_valid | held_valid;

    always_comb begin
        req_by_bank = '0;
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            merged_pr[rr]   = held_valid[rr] ? held_pr[rr] : read_req_pr[rr];
            merged_bank[rr] = merged_pr[rr][LOG_BANK_COUNT-1:0];
            req_by_bank[merged_bank[rr]][rr] = merged_valid[rr];
        end
    end

    // port 1 competes without the port 0 winner
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        prf_rotate_pick #(.WIDTH(RR_COUNT)) i_port0_pick (
            .req       (req_by_bank[b]),
            .last_mask (last_mask[b]),
            .grant     (port0_grant[b])
        );

        prf_rotate_pick #(.WIDTH(RR_COUNT)) i_port1_pick (
            .req       (req_by_bank[b] & ~port0_grant[b]),
            .last_mask (last_mask[b]),
            .grant     (port1_grant[b])
        );
    end

    // ----------------------------------------
    // grant collection and row muxes

    always_comb begin
        next_ack  = '0;
        next_port = '0;
        next_last_mask = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            next_ack  |= port0_grant[b] | port1_grant[b];
            next_port |= port1_grant[b];
            next_port0_upper_pr[b] = '0;
            next_port1_upper_pr[b] = '0;
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                next_port0_upper_pr[b] |= upper_pr_t'(merged_pr[rr] >> LOG_BANK_COUNT)
                    & {$bits(upper_pr_t){port0_grant[b][rr]}};
                next_port1_upper_pr[b] |= upper_pr_t'(merged_pr[rr] >> LOG_BANK_COUNT)
                    & {$bits(upper_pr_t){port1_grant[b][rr]}};
            end
            // rotation follows port 1
            for (int rr = 1; rr < RR_COUNT; rr++) begin
                next_last_mask[b][rr] = port1_grant[b][rr-1] | next_last_mask[b][rr-1];
            end
        end
    end

    assign next_held_valid = merged_valid & ~next_ack;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid     <= '0;
            last_mask      <= '0;
            read_resp_ack  <= '0;
            read_resp_port <= '0;
        end else begin
            held_valid     <= next_held_valid;
            last_mask      <= next_last_mask;
            read_resp_ack  <= next_ack;
            read_resp_port <= next_port;
        end
    end

    always_ff @(posedge CLK) begin
        held_pr <= merged_pr;
    end

endmodule

/* hdl/prf_rotate_pick.sv */
// ----------------------------------------
// rotating priority one-hot picker
// ----------------------------------------
`timescale 1ns/1ps

module prf_rotate_pick #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    input  logic [WIDTH-1:0] last_mask,
    output logic [WIDTH-1:0] grant
);

    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] masked_low;
    logic [WIDTH-1:0] unmasked_low;

    // requests above the last winner
    assign masked_req = req & last_mask;

    // isolate lowest set bit
    assign masked_low   = masked_req & (~masked_req + 1'b1);
    assign unmasked_low = req & (~req + 1'b1);

    // wrap around to the bottom when nothing above the last winner
    assign grant = (|masked_req) ? masked_low : unmasked_low;

endmodule

/* hdl/prf_bank_write_if.sv */
// ----------------------------------------
// per-bank writeback stage
// ----------------------------------------
`timescale 1ns/1ps

interface prf_bank_write_if;
    import prf_pkg::*;

    // one entry per bank
    logic       [BANK_COUNT-1:0] wb_valid;
    upper_pr_t  [BANK_COUNT-1:0] wb_upper_pr;
    reg_data_t  [BANK_COUNT-1:0] wb_data;
    logic       [BANK_COUNT-1:0] complete_valid;
    rob_index_t [BANK_COUNT-1:0] complete_rob_index;

    // writeback arbiter side
    modport source (
        output wb_valid, wb_upper_pr, wb_data, complete_valid, complete_rob_index
    );

    // storage side only needs the write itself
    modport sink (
        input wb_valid, wb_upper_pr, wb_data
    );

endinterface

/* hdl/prf_pkg.sv */
// ----------------------------------------
// register file core constants and types
// ----------------------------------------
package prf_pkg;

    // ----------------------------------------
    // core constants

    localparam int PR_COUNT        = 128;
    localparam int BANK_COUNT      = 4;
    localparam int LOG_BANK_COUNT  = 2;
    localparam int LOG_ROB_ENTRIES = 7;

    // ----------------------------------------
    // vector types

    // physical register number, low bits pick the bank
    typedef logic [$clog2(PR_COUNT)-1:0] pr_t;

    // row within one bank
    typedef logic [$clog2(PR_COUNT)-LOG_BANK_COUNT-1:0] upper_pr_t;

    typedef logic [LOG_BANK_COUNT-1:0] bank_t;

    typedef logic [31:0] reg_data_t;

    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

endpackage
